// File: rtl/cdp_defines.svh
//////////////////////////////////////////////////////////////////////
// cdp statistics constants
//////////////////////////////////////////////////////////////////////

`ifndef CDP_DEFINES_SVH
`define CDP_DEFINES_SVH

`default_nettype none

`define CDP_N_PORTS       8             // switch ports
`define CDP_CNT_WIDTH     32            // bits per event counter

// local bus address map
`define CDP_BLOCK_ID      4'h0          // addr[31:28] for this block
`define CDP_CLEAR_OFFSET  8'h00
`define CDP_CLEAR_CMD     32'h0000_0001 // clear register trigger value
`define CDP_PREAM_BASE    8'h21         // preamble counters start here

// cycles the clear stays high before ack
`define CDP_CLEAR_HOLD    10

`default_nettype wire

`endif

// File: rtl/cdp_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// local bus slave types
//////////////////////////////////////////////////////////////////////

`default_nettype none

package cdp_bus_pkg;

    // host transaction sequence
    typedef enum logic [2:0]
    {
        st_idle        = 3'd0, // wait for ale
        st_judge_addr  = 3'd1, // latch address, check block id
        st_wait_cs     = 3'd2,
        st_judge_clear = 3'd3,
        st_enable_ack  = 3'd4, // clear hold then ack
        st_release     = 3'd5  // wait for cs_n high
    } bus_state_t;

    // low byte of the latched address
    typedef logic [7:0] reg_offset_t;

endpackage

`default_nettype wire

// File: rtl/cdp_stat_pkg.sv
//////////////////////////////////////////////////////////////////////
// port statistics types
//////////////////////////////////////////////////////////////////////

`include "cdp_defines.svh"

`default_nettype none

package cdp_stat_pkg;

    typedef logic [`CDP_CNT_WIDTH-1:0] stat_count_t;

    // first four follow the per-port offset order
    typedef enum logic [2:0]
    {
        kind_receive = 3'd0,
        kind_discard = 3'd1,
        kind_error   = 3'd2,
        kind_send    = 3'd3,
        kind_pream   = 3'd4
    } stat_kind_t;

    localparam int stat_kinds = 5; // members of stat_kind_t

endpackage

`default_nettype wire

// File: rtl/cdp_bus_slave.sv
//////////////////////////////////////////////////////////////////////
// cdp local bus slave
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cdp_defines.svh"

`default_nettype none

module cdp_bus_slave
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       ale,
    input  wire logic                       cs_n,
    input  wire logic                       rd_wr,
    input  wire logic [31:0]                data,
    input  wire cdp_stat_pkg::stat_count_t  rd_data,
    input  wire logic                       clear_sel,
    output logic [31:0]                     data_out,
    output logic                            ack_n,
    output cdp_bus_pkg::reg_offset_t        reg_offset,
    output cdp_stat_pkg::stat_count_t       clear_value,
    output logic                            freeze,
    output logic                            clear
);

    localparam int HW = $clog2(`CDP_CLEAR_HOLD + 1);

    cdp_bus_pkg::bus_state_t    state;
    logic [31:0]                addr_reg;
    cdp_stat_pkg::stat_count_t  clear_reg;
    logic [HW-1:0]              hold_cnt;
    logic                       addr_en;

    // address follows data for as long as ale is high
    assign addr_en = ale && (state == cdp_bus_pkg::st_idle ||
                             state == cdp_bus_pkg::st_judge_addr);

    always_ff @(posedge clk)
    begin
        if (addr_en)
        begin
            addr_reg <= data;
        end
    end

    assign reg_offset  = cdp_bus_pkg::reg_offset_t'(addr_reg[7:0]);
    assign clear_value = clear_reg;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state     <= cdp_bus_pkg::st_idle;
            data_out  <= '0;
            ack_n     <= 1'b1;
            clear_reg <= '0;
            freeze    <= 1'b0;
            clear     <= 1'b0;
            hold_cnt  <= '0;
        end
        else
        begin
            case (state)
                cdp_bus_pkg::st_idle:
                begin
                    if (ale)
                    begin
                        freeze <= rd_wr; // reads stop the snapshots
                        state  <= cdp_bus_pkg::st_judge_addr;
                    end
                end
                cdp_bus_pkg::st_judge_addr:
                begin
                    if (ale)
                    begin
                        freeze <= rd_wr;
                    end
                    else if (addr_reg[31:28] == `CDP_BLOCK_ID)
                    begin
                        state <= cdp_bus_pkg::st_wait_cs;
                    end
                    else
                    begin
                        freeze <= 1'b0; // not ours, stay silent
                        state  <= cdp_bus_pkg::st_idle;
                    end
                end
                cdp_bus_pkg::st_wait_cs:
                begin
                    if (!cs_n)
                    begin
                        if (freeze) // freeze doubles as read flag
                        begin
                            data_out <= rd_data;
                        end
                        else if (clear_sel)
                        begin
                            clear_reg <= data;
                        end
                        state <= cdp_bus_pkg::st_judge_clear;
                    end
                end
                cdp_bus_pkg::st_judge_clear:
                begin
                    if (clear_reg == `CDP_CLEAR_CMD)
                    begin
                        clear_reg <= '0;
                        clear     <= 1'b1;
                        hold_cnt  <= '0;
                    end
                    state <= cdp_bus_pkg::st_enable_ack;
                end
                cdp_bus_pkg::st_enable_ack:
                begin
                    if (!clear)
                    begin
                        ack_n <= 1'b0;
                        state <= cdp_bus_pkg::st_release;
                    end
                    else if (hold_cnt == HW'(`CDP_CLEAR_HOLD - 1))
                    begin
                        ack_n <= 1'b0; // ack marks end of clear
                        clear <= 1'b0;
                        state <= cdp_bus_pkg::st_release;
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                cdp_bus_pkg::st_release:
                begin
                    if (cs_n)
                    begin
                        ack_n  <= 1'b1;
                        freeze <= 1'b0;
                        state  <= cdp_bus_pkg::st_idle;
                    end
                end
                default:
                begin
                    state <= cdp_bus_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cdp_port_counters.sv
//////////////////////////////////////////////////////////////////////
// per-port event counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cdp_defines.svh"

`default_nettype none

module cdp_port_counters
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   freeze,
    input  wire logic                   clear,
    input  wire logic                   receive,
    input  wire logic                   discard,
    input  wire logic                   pream,
    input  wire logic                   error,
    input  wire logic                   send,
    output cdp_stat_pkg::stat_count_t   receive_count,
    output cdp_stat_pkg::stat_count_t   discard_count,
    output cdp_stat_pkg::stat_count_t   error_count,
    output cdp_stat_pkg::stat_count_t   send_count,
    output cdp_stat_pkg::stat_count_t   pream_count
);

    localparam int NK = cdp_stat_pkg::stat_kinds;

    logic [NK-1:0]              ev;
    cdp_stat_pkg::stat_count_t  work [NK]; // live counts
    cdp_stat_pkg::stat_count_t  snap [NK]; // host visible

    assign ev[cdp_stat_pkg::kind_receive] = receive;
    assign ev[cdp_stat_pkg::kind_discard] = discard;
    assign ev[cdp_stat_pkg::kind_error]   = error;
    assign ev[cdp_stat_pkg::kind_send]    = send;
    assign ev[cdp_stat_pkg::kind_pream]   = pream;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            work <= '{default: '0};
            snap <= '{default: '0};
        end
        else if (clear)
        begin
            work <= '{default: '0};
            snap <= '{default: '0};
        end
        else
        begin
            for (int i = 0; i < NK; i++)
            begin
                if (ev[i])
                begin
                    work[i] <= work[i] + 1'b1;
                end
                if (!freeze)
                begin
                    snap[i] <= work[i]; // one cycle behind
                end
            end
        end
    end

    assign receive_count = snap[cdp_stat_pkg::kind_receive];
    assign discard_count = snap[cdp_stat_pkg::kind_discard];
    assign error_count   = snap[cdp_stat_pkg::kind_error];
    assign send_count    = snap[cdp_stat_pkg::kind_send];
    assign pream_count   = snap[cdp_stat_pkg::kind_pream];

endmodule

`default_nettype wire

// File: rtl/cdp_stat_read_mux.sv
//////////////////////////////////////////////////////////////////////
// counter read select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cdp_defines.svh"

`default_nettype none

module cdp_stat_read_mux
(
    input  wire cdp_bus_pkg::reg_offset_t   reg_offset,
    input  wire cdp_stat_pkg::stat_count_t  clear_value,
    input  wire cdp_stat_pkg::stat_count_t  receive_counts [`CDP_N_PORTS],
    input  wire cdp_stat_pkg::stat_count_t  discard_counts [`CDP_N_PORTS],
    input  wire cdp_stat_pkg::stat_count_t  error_counts   [`CDP_N_PORTS],
    input  wire cdp_stat_pkg::stat_count_t  send_counts    [`CDP_N_PORTS],
    input  wire cdp_stat_pkg::stat_count_t  pream_counts   [`CDP_N_PORTS],
    output cdp_stat_pkg::stat_count_t       rd_data,
    output logic                            clear_sel
);

    localparam int PW = $clog2(`CDP_N_PORTS);

    cdp_bus_pkg::reg_offset_t   rel;
    cdp_stat_pkg::stat_kind_t   kind;
    logic [PW-1:0]              port_sel;
    logic                       mapped;

    assign clear_sel = (reg_offset == `CDP_CLEAR_OFFSET);
    assign rel       = reg_offset - 8'd1; // four counters per port from 0x01

    always_comb
    begin
        kind     = cdp_stat_pkg::kind_receive;
        port_sel = '0;
        mapped   = 1'b0;
        if (reg_offset >= 8'd1 && reg_offset <= 8'(4 * `CDP_N_PORTS))
        begin
            mapped   = 1'b1;
            port_sel = PW'(rel >> 2);
            kind     = cdp_stat_pkg::stat_kind_t'({1'b0, rel[1:0]});
        end
        else if (reg_offset >= `CDP_PREAM_BASE &&
                 reg_offset < `CDP_PREAM_BASE + 8'(`CDP_N_PORTS))
        begin
            mapped   = 1'b1;
            port_sel = PW'(reg_offset - `CDP_PREAM_BASE);
            kind     = cdp_stat_pkg::kind_pream;
        end
    end

    always_comb
    begin
        rd_data = '0; // unmapped reads as zero
        if (clear_sel)
        begin
            rd_data = clear_value;
        end
        else if (mapped)
        begin
            case (kind)
                cdp_stat_pkg::kind_receive: rd_data = receive_counts[port_sel];
                cdp_stat_pkg::kind_discard: rd_data = discard_counts[port_sel];
                cdp_stat_pkg::kind_error:   rd_data = error_counts[port_sel];
                cdp_stat_pkg::kind_send:    rd_data = send_counts[port_sel];
                default:                    rd_data = pream_counts[port_sel];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cdp_stat_top.sv
//////////////////////////////////////////////////////////////////////
// cdp packet statistics top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cdp_defines.svh"

`default_nettype none

module cdp_stat_top
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       ale,
    input  wire logic                       cs_n,
    input  wire logic                       rd_wr,
    input  wire logic [31:0]                data,
    output logic [31:0]                     data_out,
    output logic                            ack_n,
    input  wire logic [`CDP_N_PORTS-1:0]    port_receive,
    input  wire logic [`CDP_N_PORTS-1:0]    port_discard,
    input  wire logic [`CDP_N_PORTS-1:0]    port_pream,
    input  wire logic [`CDP_N_PORTS-1:0]    port_error,
    input  wire logic [`CDP_N_PORTS-1:0]    port_send
);

    cdp_bus_pkg::reg_offset_t   reg_offset;
    cdp_stat_pkg::stat_count_t  clear_value;
    cdp_stat_pkg::stat_count_t  rd_data;
    logic                       clear_sel;
    logic                       freeze;
    logic                       clear;

    cdp_stat_pkg::stat_count_t  receive_counts [`CDP_N_PORTS];
    cdp_stat_pkg::stat_count_t  discard_counts [`CDP_N_PORTS];
    cdp_stat_pkg::stat_count_t  error_counts   [`CDP_N_PORTS];
    cdp_stat_pkg::stat_count_t  send_counts    [`CDP_N_PORTS];
    cdp_stat_pkg::stat_count_t  pream_counts   [`CDP_N_PORTS];

    cdp_bus_slave i_cdp_bus_slave
    (
        .clk         (clk),
        .reset       (reset),
        .ale         (ale),
        .cs_n        (cs_n),
        .rd_wr       (rd_wr),
        .data        (data),
        .rd_data     (rd_data),
        .clear_sel   (clear_sel),
        .data_out    (data_out),
        .ack_n       (ack_n),
        .reg_offset  (reg_offset),
        .clear_value (clear_value),
        .freeze      (freeze),
        .clear       (clear)
    );

    for (genvar p = 0; p < `CDP_N_PORTS; p++)
    begin : g_port
        cdp_port_counters i_cdp_port_counters
        (
            .clk           (clk),
            .reset         (reset),
            .freeze        (freeze),
            .clear         (clear),
            .receive       (port_receive[p]),
            .discard       (port_discard[p]),
            .pream         (port_pream[p]),
            .error         (port_error[p]),
            .send          (port_send[p]),
            .receive_count (receive_counts[p]),
            .discard_count (discard_counts[p]),
            .error_count   (error_counts[p]),
            .send_count    (send_counts[p]),
            .pream_count   (pream_counts[p])
        );
    end

    cdp_stat_read_mux i_cdp_stat_read_mux
    (
        .reg_offset     (reg_offset),
        .clear_value    (clear_value),
        .receive_counts (receive_counts),
        .discard_counts (discard_counts),
        .error_counts   (error_counts),
        .send_counts    (send_counts),
        .pream_counts   (pream_counts),
        .rd_data        (rd_data),
        .clear_sel      (clear_sel)
    );

endmodule

`default_nettype wire

// File: test/cdp_stat_assertions.sv
//////////////////////////////////////////////////////////////////////
// local bus protocol checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`default_nettype none

module cdp_stat_assertions
(
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        ale,
    input wire logic        cs_n,
    input wire logic        ack_n,
    input wire logic [31:0] data_out
);

    int ale_fails     = 0;
    int stable_fails  = 0;
    int release_fails = 0;
    int fail_count;

    assign fail_count = ale_fails + stable_fails + release_fails;

    // no ack during the address phase
    no_ack_in_ale: assert property (@(posedge clk) disable iff (!reset)
        !(ale && !ack_n))
    else
    begin
        $error("ack_n low while ale high");
        ale_fails++;
    end

    data_held: assert property (@(posedge clk) disable iff (!reset)
        !ack_n |=> (ack_n || $stable(data_out)))
    else
    begin
        $error("data_out changed while ack_n low");
        stable_fails++;
    end

    // host releases cs_n first
    release_after_cs: assert property (@(posedge clk) disable iff (!reset)
        $rose(ack_n) |-> $past(cs_n))
    else
    begin
        $error("ack_n rose before cs_n was high");
        release_fails++;
    end

endmodule

bind cdp_stat_top cdp_stat_assertions i_cdp_stat_assertions
(
    .clk      (clk),
    .reset    (reset),
    .ale      (ale),
    .cs_n     (cs_n),
    .ack_n    (ack_n),
    .data_out (data_out)
);

`default_nettype wire

// File: test/cdp_stat_tb.sv
//////////////////////////////////////////////////////////////////////
// cdp statistics testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cdp_defines.svh"

`default_nettype none

module cdp_stat_tb;

    localparam int n_ports      = `CDP_N_PORTS;
    localparam int ack_timeout  = 40;   // covers the clear hold
    localparam int foreign_wait = 20;
    localparam int k_receive    = 0;    // model columns in offset order
    localparam int k_discard    = 1;
    localparam int k_error      = 2;
    localparam int k_send       = 3;
    localparam int k_pream      = 4;

    logic               clk;
    logic               reset;
    logic               ale;
    logic               cs_n;
    logic               rd_wr;
    logic [31:0]        data;
    logic [31:0]        data_out;
    logic               ack_n;
    logic [n_ports-1:0] port_receive;
    logic [n_ports-1:0] port_discard;
    logic [n_ports-1:0] port_pream;
    logic [n_ports-1:0] port_error;
    logic [n_ports-1:0] port_send;

    logic [31:0]        model [n_ports][5];
    logic [31:0]        clear_model;
    integer             seed;
    int                 checks;
    int                 mismatches;
    int                 failures;
    int                 assert_fails;
    logic [31:0]        foreign_data;
    logic               foreign_ack;

    cdp_stat_top i_cdp_stat_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] expected_value(input int off);
        logic [31:0] result;
        result = 32'h0;
        if (off == 0)
        begin
            result = clear_model;
        end
        else if (off >= 1 && off <= 4 * n_ports)
        begin
            result = model[(off - 1) / 4][(off - 1) % 4];
        end
        else if (off >= 'h21 && off < 'h21 + n_ports)
        begin
            result = model[off - 'h21][k_pream];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        checks++;
        assert (act_val === exp_val)
        else
        begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
            mismatches++;
        end
    endtask

    task automatic zero_events();
        port_receive = '0;
        port_discard = '0;
        port_pream   = '0;
        port_error   = '0;
        port_send    = '0;
    endtask

    task automatic drive_random_events();
        logic [31:0] bits [5];
        for (int k = 0; k < 5; k++)
        begin
            bits[k] = $random(seed);
            for (int p = 0; p < n_ports; p++)
            begin
                if (bits[k][p])
                begin
                    model[p][k] += 32'd1;
                end
            end
        end
        port_receive = bits[k_receive][n_ports-1:0];
        port_discard = bits[k_discard][n_ports-1:0];
        port_error   = bits[k_error][n_ports-1:0];
        port_send    = bits[k_send][n_ports-1:0];
        port_pream   = bits[k_pream][n_ports-1:0];
    endtask

    // one pulse of every kind on a single port
    task automatic inject_events(input int p);
        port_receive[p] = 1'b1;
        port_discard[p] = 1'b1;
        port_error[p]   = 1'b1;
        port_send[p]    = 1'b1;
        port_pream[p]   = 1'b1;
        for (int k = 0; k < 5; k++)
        begin
            model[p][k] += 32'd1;
        end
    endtask

    task automatic wait_ack_low(input int inject_port, input int limit,
                                output logic got_ack);
        int cycles;
        cycles  = 0;
        got_ack = 1'b0;
        while (!got_ack && cycles < limit)
        begin
            if (inject_port >= 0)
            begin
                inject_events(inject_port);
            end
            @(posedge clk);
            #1;
            zero_events();
            got_ack = !ack_n;
            cycles++;
        end
    endtask

    task automatic wait_ack_high();
        int cycles;
        cycles = 0;
        while (!ack_n && cycles < ack_timeout)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ack_n)
        begin
            $display("ack_n stayed low after cs_n was raised");
            failures++;
        end
    endtask

    task automatic bus_access
    (
        input  logic        is_read,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        input  int          inject_port,
        input  int          limit,
        output logic [31:0] rdata,
        output logic        got_ack
    );
        @(posedge clk);
        #1;
        ale   = 1'b1;
        rd_wr = is_read;
        data  = addr;
        if (inject_port >= 0)
        begin
            inject_events(inject_port); // lands on the freeze edge
        end
        @(posedge clk);
        #1;
        zero_events();
        ale = 1'b0;
        if (inject_port >= 0)
        begin
            inject_events(inject_port);
        end
        @(posedge clk);
        #1;
        zero_events();
        cs_n = 1'b0;
        data = wdata;
        wait_ack_low(inject_port, limit, got_ack);
        rdata = data_out;
        cs_n  = 1'b1;
        if (got_ack)
        begin
            wait_ack_high();
        end
    endtask

    task automatic read_check(input int off, input int inject_port);
        logic [31:0] exp_val;
        logic [31:0] got;
        logic        got_ack;
        exp_val = expected_value(off); // before any injected events
        bus_access(1'b1, 32'(off), 32'h0, inject_port, ack_timeout, got, got_ack);
        if (!got_ack)
        begin
            $display("read of offset 0x%h got no ack_n", off[7:0]);
            failures++;
        end
        else
        begin
            check_value($sformatf("data_out at offset 0x%h", off[7:0]), exp_val, got);
        end
    endtask

    task automatic read_all();
        for (int off = 0; off <= 'h28; off++)
        begin
            read_check(off, -1);
        end
    endtask

    task automatic write_reg(input int off, input logic [31:0] wdata);
        logic [31:0] ignored;
        logic        got_ack;
        bus_access(1'b0, 32'(off), wdata, -1, ack_timeout, ignored, got_ack);
        if (!got_ack)
        begin
            $display("write to offset 0x%h got no ack_n", off[7:0]);
            failures++;
        end
    endtask

    task automatic run_traffic(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            drive_random_events();
        end
        @(posedge clk);
        #1;
        zero_events();
    endtask

    initial
    begin
        clk   = 1'b0;
        reset = 1'b0;
        ale   = 1'b0;
        cs_n  = 1'b1;
        rd_wr = 1'b0;
        data  = 32'h0;
        zero_events();
        seed        = 32'h9f17;
        checks      = 0;
        mismatches  = 0;
        failures    = 0;
        clear_model = 32'h0;
        for (int p = 0; p < n_ports; p++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                model[p][k] = 32'h0;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b1;

        check_value("ack_n", 32'h1, {31'h0, ack_n});
        check_value("data_out", 32'h0, data_out);
        read_all();

        run_traffic(200);
        read_all();

        read_check('h09, 2); // frozen snapshot ignores port 2 events
        read_check('h09, -1);
        read_check('h23, -1);

        write_reg(0, 32'h5a);
        clear_model = 32'h5a;
        read_all();
        write_reg(0, 32'h1);
        clear_model = 32'h0;
        for (int p = 0; p < n_ports; p++)
        begin
            for (int k = 0; k < 5; k++)
            begin
                model[p][k] = 32'h0;
            end
        end
        read_all();

        run_traffic(50);
        bus_access(1'b1, 32'h1000_0005, 32'h0, -1, foreign_wait, foreign_data, foreign_ack);
        if (foreign_ack)
        begin
            $display("ack_n went low for an address outside this block");
            failures++;
        end
        read_check('h30, -1);
        write_reg('h05, 32'hdead_beef);
        read_check('h05, -1);
        read_all();

        assert_fails = i_cdp_stat_top.i_cdp_stat_assertions.fail_count;
        $display("checks %0d, mismatches %0d, failures %0d, assertion failures %0d",
                 checks, mismatches, failures, assert_fails);
        if (mismatches == 0 && failures == 0 && assert_fails == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cdp_stat_top.f
+incdir+rtl
rtl/cdp_bus_pkg.sv
rtl/cdp_stat_pkg.sv
rtl/cdp_bus_slave.sv
rtl/cdp_port_counters.sv
rtl/cdp_stat_read_mux.sv
rtl/cdp_stat_top.sv
test/cdp_stat_assertions.sv
test/cdp_stat_tb.sv

// File: Makefile
# Verilator build and run for the cdp packet statistics block

VERILATOR ?= verilator
TOP       ?= cdp_stat_tb
FILELIST  ?= cdp_stat_top.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
